//--- source/cpu_pkg.sv
// immediate and zero-page modes only; the D flag is stored but decimal arithmetic is absent
package cpu_pkg;

  localparam int addr_w = 16;
  localparam int data_w = 8;

  // bits in reg_p
  localparam int flag_n = 7;
  localparam int flag_v = 6;
  localparam int flag_d = 3;
  localparam int flag_i = 2;
  localparam int flag_z = 1;
  localparam int flag_c = 0;

  // opcode[1:0] groups, named by their count of addressing modes
  localparam logic [1:0] grp_8 = 2'b01;
  localparam logic [1:0] grp_6 = 2'b10;
  localparam logic [1:0] grp_5 = 2'b00;

  // opcode[4:2] modes
  localparam logic [2:0] am_zp   = 3'b001;
  localparam logic [2:0] am_imm8 = 3'b010; // immediate in group 8
  localparam logic [2:0] am_imm  = 3'b000; // immediate in groups 5 and 6

  localparam logic [data_w-1:0] op_nop = 8'hEA;

  typedef enum logic [7:0] {
    st_initial = 8'h00,
    st_fetch   = 8'h01,
    st_operand = 8'h02, // zero-page address byte
    st_exec    = 8'h04,
    st_write   = 8'h08
  } cpu_state_t;

  typedef enum logic [3:0] {
    cls_nop,
    cls_load,
    cls_store,
    cls_alu_acc,
    cls_compare,
    cls_bit_test,
    cls_transfer,
    cls_inc_dec,
    cls_shift,
    cls_set_flag
  } op_class_t;

  typedef enum logic [1:0] {
    sel_a,
    sel_x,
    sel_y
  } reg_sel_t;

  typedef enum logic [2:0] {
    alu_or,
    alu_and,
    alu_eor,
    alu_add,
    alu_sub,
    alu_shl,
    alu_shr
  } alu_op_t;

  typedef struct packed {
    op_class_t  cls;
    logic       wr_a;
    logic       wr_x;
    logic       wr_y;
    reg_sel_t   src;      // operand or store register
    alu_op_t    alu_op;
    logic       zp;       // zero page, else immediate
    logic       rotate;
    logic       shl;
    logic [2:0] flag_idx;
    logic       flag_val;
  } op_ctrl_t;

  typedef struct packed {
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic              cin;
    alu_op_t           op;
  } alu_req_t;

  typedef struct packed {
    logic [data_w-1:0] f;
    logic              cout;
    logic              ovf;
  } alu_res_t;

endpackage

//--- source/op_decoder.sv
// kept opcodes only; every other encoding, including the dropped modes, decodes as a nop
`timescale 1ns/1ps

module op_decoder import cpu_pkg::*; (
  input  logic [data_w-1:0] opcode,
  output op_ctrl_t          ctrl
);

  logic [3:0] op_hi;
  logic [3:0] op_lo;
  logic [2:0] aaa;
  logic [2:0] amode;
  logic [1:0] grp;
  logic       is_zp;
  logic       is_imm;

  assign op_hi  = opcode[7:4];
  assign op_lo  = opcode[3:0];
  assign aaa    = opcode[7:5];
  assign amode  = opcode[4:2];
  assign grp    = opcode[1:0];
  assign is_zp  = amode == am_zp;
  assign is_imm = amode == ((grp == grp_8) ? am_imm8 : am_imm);

  always_comb begin
    ctrl.cls      = cls_nop;
    ctrl.wr_a     = 1'b0;
    ctrl.wr_x     = 1'b0;
    ctrl.wr_y     = 1'b0;
    ctrl.src      = sel_a;
    ctrl.alu_op   = alu_add;
    ctrl.zp       = is_zp;
    ctrl.rotate   = 1'b0;
    ctrl.shl      = 1'b0;
    ctrl.flag_idx = 3'(flag_c);
    ctrl.flag_val = op_hi[1];

    if (op_lo == 4'h8 && op_hi[0] && op_hi != 4'h9) begin // clc sec cli sei clv cld sed
      ctrl.cls = cls_set_flag;
      case (op_hi[3:2])
        2'b00: ctrl.flag_idx = 3'(flag_c);
        2'b01: ctrl.flag_idx = 3'(flag_i);
        2'b10: begin
          ctrl.flag_idx = 3'(flag_v);
          ctrl.flag_val = 1'b0; // clv only
        end
        default: ctrl.flag_idx = 3'(flag_d);
      endcase
    end else if (op_lo == 4'h8 || op_lo == 4'hA) begin
      // implied register ops
      case (opcode)
        8'h8A: begin ctrl.cls = cls_transfer; ctrl.src = sel_x; ctrl.wr_a = 1'b1; end
        8'h98: begin ctrl.cls = cls_transfer; ctrl.src = sel_y; ctrl.wr_a = 1'b1; end
        8'hAA: begin ctrl.cls = cls_transfer; ctrl.src = sel_a; ctrl.wr_x = 1'b1; end
        8'hA8: begin ctrl.cls = cls_transfer; ctrl.src = sel_a; ctrl.wr_y = 1'b1; end
        8'hE8: begin ctrl.cls = cls_inc_dec; ctrl.src = sel_x; ctrl.wr_x = 1'b1; end
        8'hC8: begin ctrl.cls = cls_inc_dec; ctrl.src = sel_y; ctrl.wr_y = 1'b1; end
        8'hCA: begin
          ctrl.cls    = cls_inc_dec;
          ctrl.src    = sel_x;
          ctrl.wr_x   = 1'b1;
          ctrl.alu_op = alu_sub;
        end
        8'h88: begin
          ctrl.cls    = cls_inc_dec;
          ctrl.src    = sel_y;
          ctrl.wr_y   = 1'b1;
          ctrl.alu_op = alu_sub;
        end
        8'h0A, 8'h2A, 8'h4A, 8'h6A: begin // accumulator shifts
          ctrl.cls    = cls_shift;
          ctrl.wr_a   = 1'b1;
          ctrl.rotate = op_hi[1];
          ctrl.shl    = ~op_hi[2];
        end
        default: ;
      endcase
    end else if (is_zp || is_imm) begin
      case (grp)
        grp_8: begin
          case (aaa)
            3'b000: begin ctrl.cls = cls_alu_acc; ctrl.wr_a = 1'b1; ctrl.alu_op = alu_or; end
            3'b001: begin ctrl.cls = cls_alu_acc; ctrl.wr_a = 1'b1; ctrl.alu_op = alu_and; end
            3'b010: begin ctrl.cls = cls_alu_acc; ctrl.wr_a = 1'b1; ctrl.alu_op = alu_eor; end
            3'b011: begin ctrl.cls = cls_alu_acc; ctrl.wr_a = 1'b1; end
            3'b100: if (is_zp) ctrl.cls = cls_store;
            3'b101: begin ctrl.cls = cls_load; ctrl.wr_a = 1'b1; end
            3'b110: begin ctrl.cls = cls_compare; ctrl.alu_op = alu_sub; end
            default: begin ctrl.cls = cls_alu_acc; ctrl.wr_a = 1'b1; ctrl.alu_op = alu_sub; end
          endcase
        end
        grp_6: begin
          ctrl.src = sel_x;
          if (aaa == 3'b101) begin
            ctrl.cls  = cls_load;
            ctrl.wr_x = 1'b1;
          end else if (aaa == 3'b100 && is_zp) begin
            ctrl.cls = cls_store;
          end
        end
        grp_5: begin
          case (aaa)
            3'b001: if (is_zp) begin ctrl.cls = cls_bit_test; ctrl.alu_op = alu_and; end
            3'b100: if (is_zp) begin ctrl.cls = cls_store; ctrl.src = sel_y; end
            3'b101: begin ctrl.cls = cls_load; ctrl.wr_y = 1'b1; end
            3'b110: begin ctrl.cls = cls_compare; ctrl.src = sel_y; ctrl.alu_op = alu_sub; end
            3'b111: begin ctrl.cls = cls_compare; ctrl.src = sel_x; ctrl.alu_op = alu_sub; end
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

endmodule

//--- source/cpu_sequencer.sv
// no branches or jumps, so the PC only counts up; stores are zero-page only
`timescale 1ns/1ps

module cpu_sequencer import cpu_pkg::*; #(
  parameter logic [addr_w-1:0] RESET_PC = '0
) (
  input  logic              CLK,
  input  logic              R,
  input  logic [data_w-1:0] mem_rdata,
  input  op_ctrl_t          ctrl,
  output logic [data_w-1:0] opcode,
  output cpu_state_t        state,
  output logic [addr_w-1:0] mem_addr,
  output logic              mem_we,
  output logic              sync
);

  cpu_state_t        state_nxt;
  logic [data_w-1:0] op_q;
  logic [data_w-1:0] zp_q;   // zero-page address latch
  logic [addr_w-1:0] pc;
  logic [addr_w-1:0] zp_addr;
  logic              mem_op; // has a memory operand
  logic              pc_inc;

  assign mem_op = ctrl.cls inside {cls_load, cls_store, cls_alu_acc, cls_compare, cls_bit_test};

  // decoder sees the bus byte while fetching
  assign opcode  = (state == st_fetch) ? mem_rdata : op_q;
  assign sync    = state == st_fetch;
  assign mem_we  = state == st_write;
  assign zp_addr = {{(addr_w - data_w){1'b0}}, zp_q};

  // opcode, zero-page address and immediate bytes are consumed
  assign pc_inc = state == st_fetch || state == st_operand ||
                  (state == st_exec && mem_op && !ctrl.zp);

  always_comb begin
    case (state)
      st_initial: state_nxt = st_fetch;
      st_fetch: begin
        if (ctrl.cls == cls_set_flag || ctrl.cls == cls_nop)
          state_nxt = st_fetch; // done in one cycle
        else if (mem_op && ctrl.zp)
          state_nxt = st_operand;
        else
          state_nxt = st_exec;
      end
      st_operand: begin
        if (ctrl.cls == cls_store)
          state_nxt = st_write;
        else
          state_nxt = st_exec;
      end
      default: state_nxt = st_fetch;
    endcase
  end

  always_comb begin
    case (state)
      st_exec: begin
        if (mem_op && ctrl.zp)
          mem_addr = zp_addr;
        else
          mem_addr = pc; // immediate byte
      end
      st_write: mem_addr = zp_addr;
      default:  mem_addr = pc;
    endcase
  end

  always_ff @(posedge CLK or posedge R) begin
    if (R) begin
      state <= st_initial;
      pc    <= RESET_PC;
      op_q  <= op_nop;
    end else begin
      state <= state_nxt;
      if (pc_inc)
        pc <= pc + addr_w'(1);
      if (state == st_fetch)
        op_q <= mem_rdata;
    end
  end

  always_ff @(posedge CLK) begin
    if (state == st_operand)
      zp_q <= mem_rdata;
  end

endmodule

//--- source/alu8.sv
// binary arithmetic only; overflow is meaningful for add and subtract alone
`timescale 1ns/1ps

module alu8 import cpu_pkg::*; (
  input  alu_req_t req,
  output alu_res_t res
);

  logic [data_w-1:0] b_eff;
  logic [data_w:0]   sum;

  // subtract is a + ~b + cin
  assign b_eff = (req.op == alu_sub) ? ~req.b : req.b;
  assign sum   = {1'b0, req.a} + {1'b0, b_eff} + {{data_w{1'b0}}, req.cin};

  always_comb begin
    res.f    = '0;
    res.cout = 1'b0;
    res.ovf  = 1'b0;
    case (req.op)
      alu_or:  res.f = req.a | req.b;
      alu_and: res.f = req.a & req.b;
      alu_eor: res.f = req.a ^ req.b;
      alu_add, alu_sub: begin
        {res.cout, res.f} = sum;
        // same operand signs, different result sign
        res.ovf = (req.a[data_w-1] ~^ b_eff[data_w-1]) &
                  (sum[data_w-1] ^ req.a[data_w-1]);
      end
      alu_shl: {res.cout, res.f} = {req.a, req.cin};
      alu_shr: {res.f, res.cout} = {req.cin, req.a};
      default: res.f = req.a;
    endcase
  end

endmodule

//--- source/reg_file.sv
// A, X, Y and P only; no stack pointer, and D is held for software but never acted on
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
  input  logic              CLK,
  input  logic              R,
  input  cpu_state_t        state,
  input  op_ctrl_t          ctrl,
  input  logic [data_w-1:0] mem_rdata,
  input  alu_res_t          res,
  output alu_req_t          req,
  output logic [data_w-1:0] mem_wdata,
  output logic [data_w-1:0] reg_a,
  output logic [data_w-1:0] reg_x,
  output logic [data_w-1:0] reg_y,
  output logic [data_w-1:0] reg_p
);

  logic [data_w-1:0] src_val;
  logic              res_zero;
  logic              arith;

  always_comb begin
    case (ctrl.src)
      sel_x:   src_val = reg_x;
      sel_y:   src_val = reg_y;
      default: src_val = reg_a;
    endcase
  end

  assign mem_wdata = src_val; // sta, stx, sty
  assign res_zero  = res.f == '0;
  assign arith     = ctrl.alu_op inside {alu_add, alu_sub};

  // loads pass the memory byte through, transfers and inc/dec use register vs zero
  always_comb begin
    req.a   = src_val;
    req.b   = '0;
    req.cin = 1'b0;
    req.op  = ctrl.alu_op;
    case (ctrl.cls)
      cls_load: req.a = mem_rdata;
      cls_alu_acc: begin
        req.b   = mem_rdata;
        req.cin = reg_p[flag_c];
      end
      cls_compare: begin
        req.b   = mem_rdata;
        req.cin = 1'b1; // plain subtract
      end
      cls_bit_test: req.b = mem_rdata;
      cls_inc_dec:  req.cin = ctrl.alu_op == alu_add; // dec adds ff
      cls_shift: begin
        req.op  = ctrl.shl ? alu_shl : alu_shr;
        req.cin = ctrl.rotate & reg_p[flag_c];
      end
      default: ;
    endcase
  end

  always_ff @(posedge CLK or posedge R) begin
    if (R) begin
      reg_a <= '0;
      reg_x <= '0;
      reg_y <= '0;
      reg_p <= '0;
    end else if (state == st_fetch && ctrl.cls == cls_set_flag) begin
      reg_p[ctrl.flag_idx] <= ctrl.flag_val;
    end else if (state == st_exec) begin
      if (ctrl.wr_a)
        reg_a <= res.f;
      if (ctrl.wr_x)
        reg_x <= res.f;
      if (ctrl.wr_y)
        reg_y <= res.f;

      case (ctrl.cls)
        cls_bit_test: begin
          reg_p[flag_z] <= res_zero;
          reg_p[flag_n] <= mem_rdata[7];
          reg_p[flag_v] <= mem_rdata[6];
        end
        cls_load, cls_transfer, cls_inc_dec: begin
          reg_p[flag_z] <= res_zero;
          reg_p[flag_n] <= res.f[data_w-1];
        end
        cls_alu_acc: begin
          reg_p[flag_z] <= res_zero;
          reg_p[flag_n] <= res.f[data_w-1];
          if (arith) begin // adc, sbc
            reg_p[flag_c] <= res.cout;
            reg_p[flag_v] <= res.ovf;
          end
        end
        cls_compare, cls_shift: begin
          reg_p[flag_z] <= res_zero;
          reg_p[flag_n] <= res.f[data_w-1];
          reg_p[flag_c] <= res.cout;
        end
        default: ;
      endcase
    end
  end

endmodule

//--- source/cpu_core.sv
// memory is external: reads must be combinational from mem_addr, writes land on the clock edge
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; #(
  parameter logic [addr_w-1:0] RESET_PC = 16'h0200
) (
  input  logic              CLK,
  input  logic              R,
  input  logic [data_w-1:0] mem_rdata,
  output logic [addr_w-1:0] mem_addr,
  output logic [data_w-1:0] mem_wdata,
  output logic              mem_we,
  output logic              sync,
  output logic [data_w-1:0] reg_a,
  output logic [data_w-1:0] reg_x,
  output logic [data_w-1:0] reg_y,
  output logic [data_w-1:0] reg_p
);

  logic [data_w-1:0] opcode;  // live opcode
  cpu_state_t        state;
  op_ctrl_t          ctrl;
  alu_req_t          req;
  alu_res_t          res;

  cpu_sequencer #(
    .RESET_PC(RESET_PC)
  ) u_seq (
    .CLK      (CLK),
    .R        (R),
    .mem_rdata(mem_rdata),
    .ctrl     (ctrl),
    .opcode   (opcode),
    .state    (state),
    .mem_addr (mem_addr),
    .mem_we   (mem_we),
    .sync     (sync)
  );

  op_decoder u_dec (
    .opcode(opcode),
    .ctrl  (ctrl)
  );

  reg_file u_regs (
    .CLK      (CLK),
    .R        (R),
    .state    (state),
    .ctrl     (ctrl),
    .mem_rdata(mem_rdata),
    .res      (res),
    .req      (req),
    .mem_wdata(mem_wdata),
    .reg_a    (reg_a),
    .reg_x    (reg_x),
    .reg_y    (reg_y),
    .reg_p    (reg_p)
  );

  alu8 u_alu (
    .req(req),
    .res(res)
  );

endmodule

//--- verif/tb_clock.sv
// free-running clock from time zero; R is released 1 ns after the last reset edge
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 5
) (
  output logic CLK,
  output logic R
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    R = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1 R = 1'b0; // same skew as the other stimulus
  end

endmodule

//--- verif/cpu_core_props.sv
// samples on rising CLK only; the fetch gap counter saturates so a stalled core keeps failing
`timescale 1ns/1ps

module cpu_core_props (
  input logic CLK,
  input logic R,
  input logic sync,
  input logic mem_we
);

  logic [1:0] gap; // non-fetch cycles since the last fetch

  always_ff @(posedge CLK or posedge R) begin
    if (R)
      gap <= '0;
    else if (sync)
      gap <= '0;
    else if (gap != 2'd3)
      gap <= gap + 2'd1;
  end

  no_store_in_fetch: assert property (@(posedge CLK) disable iff (R) !(mem_we && sync))
    else $error("write strobe high during an opcode fetch");

  // three idle cycles in a row means sync missed its slot
  fetch_recurs: assert property (@(posedge CLK) disable iff (R) gap != 2'd3)
    else $error("no opcode fetch within three cycles");

  quiet_after_reset: assert property (@(posedge CLK) $fell(R) |-> !mem_we)
    else $error("write strobe high in the first cycle after reset");

endmodule

bind cpu_core cpu_core_props u_props (
  .CLK   (CLK),
  .R     (R),
  .sync  (sync),
  .mem_we(mem_we)
);

//--- verif/cpu_core_tb.sv
// fixed-seed program of kept opcodes at 0200 above zero page; the memory has no wait states
`timescale 1ns/1ps

module cpu_core_tb;

  localparam int n_instr    = 200;
  localparam int n_with_arg = 26; // leading entries of kept_ops that take an operand byte
  localparam int kind_reg   = 0;
  localparam int kind_flag  = 1;
  localparam int kind_set   = 2;
  localparam int t_reset    = 0;
  localparam int t_regs     = 1;
  localparam int t_store    = 2;
  localparam int t_flags    = 3;
  localparam int t_spacing  = 4;
  localparam int t_setflag  = 5;

  logic        CLK;
  logic        R;
  logic [7:0]  mem_rdata;
  logic [15:0] mem_addr;
  logic [7:0]  mem_wdata;
  logic        mem_we;
  logic        sync;
  logic [7:0]  reg_a;
  logic [7:0]  reg_x;
  logic [7:0]  reg_y;
  logic [7:0]  reg_p;

  logic [7:0]  mem [0:65535];
  logic [7:0]  kept_ops [0:45] = '{
    8'h09, 8'h29, 8'h49, 8'h69, 8'hC9, 8'hE9, 8'hA9, 8'hA2, 8'hA0, 8'hE0, 8'hC0,
    8'h05, 8'h25, 8'h45, 8'h65, 8'hC5, 8'hE5, 8'hA5, 8'hA6, 8'hA4, 8'hE4, 8'hC4, 8'h24,
    8'h85, 8'h86, 8'h84,
    8'hAA, 8'h8A, 8'hA8, 8'h98, 8'hE8, 8'hC8, 8'hCA, 8'h88, 8'h0A, 8'h2A, 8'h4A, 8'h6A,
    8'h18, 8'h38, 8'h58, 8'h78, 8'hB8, 8'hD8, 8'hF8, 8'hEA
  };
  logic [7:0]  prog_op [0:n_instr-1];
  logic [7:0]  prog_arg [0:n_instr-1];
  int          prog_len [0:n_instr-1];
  logic [31:0] seed;

  // reference model state
  logic [7:0]  m_a, m_x, m_y;
  logic        m_n, m_v, m_d, m_i, m_z, m_c;
  logic [7:0]  m_zp [0:255];

  int          n_checks [0:5] = '{default: 0};
  int          n_errors [0:5] = '{default: 0};
  string       test_name [0:5] = '{"reset", "registers", "stores", "flags",
                                   "fetch spacing", "set flag and nop"};
  bit          ok;

  tb_clock u_clk (.CLK(CLK), .R(R));

  cpu_core #(.RESET_PC(16'h0200)) uut (
    .CLK      (CLK),
    .R        (R),
    .mem_rdata(mem_rdata),
    .mem_addr (mem_addr),
    .mem_wdata(mem_wdata),
    .mem_we   (mem_we),
    .sync     (sync),
    .reg_a    (reg_a),
    .reg_x    (reg_x),
    .reg_y    (reg_y),
    .reg_p    (reg_p)
  );

  assign mem_rdata = mem[mem_addr]; // asynchronous read

  always @(posedge CLK) begin
    if (mem_we)
      mem[mem_addr] <= mem_wdata;
  end

  function automatic int next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return int'(seed[23:16]);
  endfunction

  function automatic logic [7:0] model_p();
    return {m_n, m_v, 2'b00, m_d, m_i, m_z, m_c};
  endfunction

  task automatic check_eq(input int t, input string what, input logic [15:0] got,
                          input logic [15:0] exp);
    n_checks[t]++;
    assert (got === exp) else begin
      n_errors[t]++;
      $display("ERROR t=%0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input int t);
    $display("test %s: %0d checks, %0d errors", test_name[t], n_checks[t], n_errors[t]);
  endtask

  task automatic set_nz(input logic [7:0] r);
    m_n = r[7];
    m_z = (r == 8'h00);
  endtask

  task automatic compare(input logic [7:0] r, input logic [7:0] v);
    m_c = (r >= v); // no borrow
    set_nz(r - v);
  endtask

  task automatic load_memory();
    int k;
    int idx;
    logic [15:0] addr;
    for (k = 0; k < 65536; k++)
      mem[k] <= 8'(k) ^ 8'(k >> 8) ^ 8'h5A;
    for (k = 0; k < 256; k++) begin
      m_zp[k] = 8'(next_rand());
      mem[k] <= m_zp[k];
    end
    addr = 16'h0200;
    for (k = 0; k < n_instr; k++) begin
      idx         = next_rand() % 46;
      prog_op[k]  = kept_ops[idx];
      prog_arg[k] = 8'(next_rand());
      prog_len[k] = (idx < n_with_arg) ? 2 : 1;
      mem[addr] <= prog_op[k];
      if (idx < n_with_arg)
        mem[addr + 16'd1] <= prog_arg[k];
      addr = addr + 16'(prog_len[k]);
    end
  endtask

  task automatic model_step(input logic [7:0] op, input logic [7:0] arg, output int cyc,
                            output int kind, output bit st, output logic [7:0] st_data);
    logic [7:0] v;
    logic [8:0] sum;
    bit         is_zp;
    is_zp = op inside {8'h05, 8'h25, 8'h45, 8'h65, 8'hC5, 8'hE5, 8'hA5, 8'hA6,
                       8'hA4, 8'hE4, 8'hC4, 8'h24};
    st      = op inside {8'h84, 8'h85, 8'h86};
    v       = is_zp ? m_zp[arg] : arg;
    cyc     = (is_zp || st) ? 3 : 2;
    kind    = kind_reg;
    st_data = 8'h00;
    case (op)
      8'h09, 8'h05: begin
        m_a = m_a | v;
        set_nz(m_a);
      end
      8'h29, 8'h25: begin
        m_a = m_a & v;
        set_nz(m_a);
      end
      8'h49, 8'h45: begin
        m_a = m_a ^ v;
        set_nz(m_a);
      end
      8'h69, 8'h65, 8'hE9, 8'hE5: begin
        if (op[7])
          v = ~v; // sbc adds the complement
        sum = {1'b0, m_a} + {1'b0, v} + {8'h00, m_c};
        m_v = (m_a[7] == v[7]) && (sum[7] != m_a[7]);
        m_c = sum[8];
        m_a = sum[7:0];
        set_nz(m_a);
        kind = kind_flag;
      end
      8'hC9, 8'hC5: begin
        compare(m_a, v);
        kind = kind_flag;
      end
      8'hE0, 8'hE4: begin
        compare(m_x, v);
        kind = kind_flag;
      end
      8'hC0, 8'hC4: begin
        compare(m_y, v);
        kind = kind_flag;
      end
      8'h24: begin
        m_z  = (m_a & v) == 8'h00;
        m_n  = v[7];
        m_v  = v[6];
        kind = kind_flag;
      end
      8'hA9, 8'hA5: begin
        m_a = v;
        set_nz(m_a);
      end
      8'hA2, 8'hA6: begin
        m_x = v;
        set_nz(m_x);
      end
      8'hA0, 8'hA4: begin
        m_y = v;
        set_nz(m_y);
      end
      8'h85: begin
        st_data   = m_a;
        m_zp[arg] = m_a;
      end
      8'h86: begin
        st_data   = m_x;
        m_zp[arg] = m_x;
      end
      8'h84: begin
        st_data   = m_y;
        m_zp[arg] = m_y;
      end
      8'hAA: begin
        m_x = m_a;
        set_nz(m_x);
      end
      8'h8A: begin
        m_a = m_x;
        set_nz(m_a);
      end
      8'hA8: begin
        m_y = m_a;
        set_nz(m_y);
      end
      8'h98: begin
        m_a = m_y;
        set_nz(m_a);
      end
      8'hE8: begin
        m_x = m_x + 8'd1;
        set_nz(m_x);
      end
      8'hC8: begin
        m_y = m_y + 8'd1;
        set_nz(m_y);
      end
      8'hCA: begin
        m_x = m_x - 8'd1;
        set_nz(m_x);
      end
      8'h88: begin
        m_y = m_y - 8'd1;
        set_nz(m_y);
      end
      8'h0A: begin
        m_c = m_a[7];
        m_a = m_a << 1;
        set_nz(m_a);
        kind = kind_flag;
      end
      8'h2A: begin
        {m_c, m_a} = {m_a, m_c};
        set_nz(m_a);
        kind = kind_flag;
      end
      8'h4A: begin
        m_c = m_a[0];
        m_a = m_a >> 1;
        set_nz(m_a);
        kind = kind_flag;
      end
      8'h6A: begin
        {m_a, m_c} = {m_c, m_a};
        set_nz(m_a);
        kind = kind_flag;
      end
      default: begin
        cyc  = 1; // flag ops and nop finish in the fetch cycle
        kind = kind_set;
        case (op)
          8'h18: m_c = 1'b0;
          8'h38: m_c = 1'b1;
          8'h58: m_i = 1'b0;
          8'h78: m_i = 1'b1;
          8'hB8: m_v = 1'b0;
          8'hD8: m_d = 1'b0;
          8'hF8: m_d = 1'b1;
          default: ;
        endcase
      end
    endcase
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    @(posedge CLK);
    @(negedge CLK);
    while (R && ok) begin
      check_eq(t_reset, "sync in reset", 16'(sync), 16'd0);
      check_eq(t_reset, "mem_we in reset", 16'(mem_we), 16'd0);
      check_eq(t_reset, "registers in reset", {reg_a, reg_x} | {reg_y, reg_p}, 16'd0);
      n++;
      if (n > 20) begin
        ok = 1'b0;
        $display("reset was never released");
      end else
        @(negedge CLK);
    end
    n = 0;
    while (!sync && ok) begin
      check_eq(t_reset, "mem_we after reset", 16'(mem_we), 16'd0);
      n++;
      if (n > 4) begin
        ok = 1'b0;
        $display("no opcode fetch followed the reset");
      end else
        @(negedge CLK);
    end
    check_eq(t_reset, "cycles from reset to first fetch", 16'(n), 16'd1);
    check_eq(t_reset, "first fetch address", mem_addr, 16'h0200);
    check_eq(t_reset, "reg_a and reg_x after reset", {reg_a, reg_x}, 16'd0);
    check_eq(t_reset, "reg_y and reg_p after reset", {reg_y, reg_p}, 16'd0);
    report_test(t_reset);
  endtask

  task automatic run_program();
    int          i;
    int          cyc;
    int          exp_cyc;
    int          kind;
    int          prev_kind;
    int          writes;
    int          tr;
    bit          st;
    logic [7:0]  st_data;
    logic [15:0] exp_pc;
    exp_pc    = 16'h0200;
    prev_kind = kind_reg;
    for (i = 0; i <= n_instr && ok; i++) begin
      // state left by the previous instruction as seen at this fetch
      tr = (prev_kind == kind_set) ? t_setflag : t_regs;
      check_eq(tr, "fetch address", mem_addr, exp_pc);
      check_eq(tr, "reg_a", 16'(reg_a), 16'(m_a));
      check_eq(tr, "reg_x", 16'(reg_x), 16'(m_x));
      check_eq(tr, "reg_y", 16'(reg_y), 16'(m_y));
      check_eq((prev_kind == kind_flag) ? t_flags : tr, "reg_p", 16'(reg_p), 16'(model_p()));
      check_eq(t_store, "mem_we during fetch", 16'(mem_we), 16'd0);
      if (i < n_instr) begin
        model_step(prog_op[i], prog_arg[i], exp_cyc, kind, st, st_data);
        exp_pc = exp_pc + 16'(prog_len[i]);
        cyc    = 1;
        writes = 0;
        @(negedge CLK);
        while (!sync && ok) begin
          if (mem_we) begin
            writes++;
            check_eq(t_store, "store address", mem_addr, 16'(prog_arg[i]));
            check_eq(t_store, "store data", 16'(mem_wdata), 16'(st_data));
          end
          cyc++;
          if (cyc > 8) begin
            ok = 1'b0;
            $display("instruction %0d, opcode %h, never returned to fetch", i, prog_op[i]);
          end else
            @(negedge CLK);
        end
        check_eq((kind == kind_set) ? t_setflag : t_spacing, "cycles per instruction",
                 16'(cyc), 16'(exp_cyc));
        check_eq(t_store, "write strobes", 16'(writes), st ? 16'd1 : 16'd0);
        prev_kind = kind;
      end
    end
  endtask

  initial begin
    int t;
    int n_chk;
    int n_err;
    ok    = 1'b1;
    seed  = 32'h22a881e5;
    m_a   = 8'h00;
    m_x   = 8'h00;
    m_y   = 8'h00;
    {m_n, m_v, m_d, m_i, m_z, m_c} = 6'b0;
    n_chk = 0;
    n_err = 0;
    load_memory();
    wait_reset();
    run_program();
    for (t = 1; t < 6; t++)
      report_test(t);
    for (t = 0; t < 6; t++) begin
      n_chk += n_checks[t];
      n_err += n_errors[t];
    end
    $display("6 tests, %0d checks, %0d errors", n_chk, n_err);
    if (ok && n_err == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

//--- cpu_core.f
source/cpu_pkg.sv
source/op_decoder.sv
source/cpu_sequencer.sv
source/alu8.sv
source/reg_file.sv
source/cpu_core.sv
verif/tb_clock.sv
verif/cpu_core_props.sv
verif/cpu_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it, and judges the result from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module cpu_core_tb -f cpu_core.f -o cpu_core_sim \
  && ./obj_dir/cpu_core_sim > sim.log 2>&1 \
  || echo "build or simulation stopped with an error" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && echo "simulation failed" && exit 1
grep -q "TEST PASS" sim.log || { echo "simulation gave no result"; exit 1; }
echo "simulation passed"
